// ==== hdl/icache_geom_pkg.sv ====
package icache_geom_pkg;

  // 8 KB direct mapped, 128 lines of 64 bytes
  // address split is tag | index | offset

  // tag is what remains above index and offset
  parameter int TAG_W = 19;

  // 128 lines
  parameter int IDX_W = 7;

  // 64 bytes per line
  parameter int OFS_W = 6;

  // 32-bit words in one line
  parameter int WORDS_PER_LINE = 16;

  // counts 0..15 over a line refill
  parameter int BEAT_W = 4;

  // stored line tag
  typedef logic [TAG_W-1:0] tag_t;

  // line select
  typedef logic [IDX_W-1:0] idx_t;

  // word position inside a line
  typedef logic [BEAT_W-1:0] beat_t;

  // fetch address viewed as cache fields
  // beat and byte_sel together make up the 6-bit offset
  typedef struct packed {
    tag_t       tag;
    idx_t       idx;
    beat_t      beat;
    logic [1:0] byte_sel;
  } addr_fields_t;

endpackage

// ==== hdl/icache_bus_pkg.sv ====
package icache_bus_pkg;

  // fetch and memory addresses share one width
  typedef logic [31:0] addr_t;

  // instruction word, also the memory beat width
  typedef logic [31:0] word_t;

  // read request toward memory, 44 bits
  // len counts beats minus one, 15 for a line and 0 for a single word
  // size code 4 means 4 bytes per beat
  typedef struct packed {
    addr_t      addr;
    logic [7:0] len;
    logic [3:0] size;
  } mem_req_t;

  // controller states
  // idle also serves as the state right after reset
  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED
  } ctrl_state_t;

endpackage

// ==== hdl/icache_tag_store.sv ====
module icache_tag_store (
  input  logic                  clk,
  input  logic                  rst,

  // lookup side, compared combinationally
  input  icache_geom_pkg::tag_t look_tag_i,
  input  icache_geom_pkg::idx_t look_idx_i,
  output logic                  hit_o,

  // tag write after a completed refill
  input  logic                  we_i,
  input  icache_geom_pkg::tag_t wr_tag_i,
  input  icache_geom_pkg::idx_t wr_idx_i
);

  localparam int LINES = 2 ** icache_geom_pkg::IDX_W;

  // one valid bit per line
  logic [LINES-1:0] valid_q;

  // tag per line
  icache_geom_pkg::tag_t tags_q [LINES];

  // valid bits come up clear so every line misses first
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[wr_idx_i] <= 1'b1;
    end
  end

  // tag array
  always_ff @(posedge clk) begin
    if (we_i) begin
      tags_q[wr_idx_i] <= wr_tag_i;
    end
  end

  // hit needs a valid line and a matching tag
  always_comb begin
    hit_o = valid_q[look_idx_i] && (tags_q[look_idx_i] == look_tag_i);
  end

endmodule

// ==== hdl/icache_data_store.sv ====
module icache_data_store (
  input  logic                   clk,

  // refill write port, one word per beat
  input  logic                   we_i,
  input  icache_geom_pkg::idx_t  wr_idx_i,
  input  icache_geom_pkg::beat_t wr_beat_i,
  input  icache_bus_pkg::word_t  wr_word_i,

  // read port, word shows up one cycle later
  input  icache_geom_pkg::idx_t  rd_idx_i,
  input  icache_geom_pkg::beat_t rd_beat_i,
  output icache_bus_pkg::word_t  rd_word_o
);

  // 128 lines x 16 words
  localparam int DEPTH = (2 ** icache_geom_pkg::IDX_W) * icache_geom_pkg::WORDS_PER_LINE;
  localparam int AW    = icache_geom_pkg::IDX_W + icache_geom_pkg::BEAT_W;

  // word array
  icache_bus_pkg::word_t mem_q [DEPTH];

  // flat word addresses, line index on top
  logic [AW-1:0] wr_addr;
  logic [AW-1:0] rd_addr;

  // registered read data
  icache_bus_pkg::word_t rd_word_q;

  always_comb begin
    wr_addr = {wr_idx_i, wr_beat_i};
    rd_addr = {rd_idx_i, rd_beat_i};
  end

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[wr_addr] <= wr_word_i;
    end
  end

  // read before write on the same address is never used,
  // refill and lookup do not overlap
  always_ff @(posedge clk) begin
    rd_word_q <= mem_q[rd_addr];
  end

  always_comb begin
    rd_word_o = rd_word_q;
  end

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl #(
  parameter icache_bus_pkg::addr_t UNCACHED_BASE = 32'h1000_0000,
  parameter icache_bus_pkg::addr_t UNCACHED_MASK = 32'hF000_0000
) (
  input  logic                     clk,
  input  logic                     rst,

  // fetch side
  input  icache_bus_pkg::addr_t    fetch_addr_i,
  input  logic                     fetch_valid_i,
  output icache_bus_pkg::word_t    fetch_rdata_o,
  output logic                     fetch_rdata_valid_o,

  // memory side
  output icache_bus_pkg::mem_req_t mem_req_o,
  output logic                     mem_req_valid_o,
  input  icache_bus_pkg::word_t    mem_rdata_i,
  input  logic                     mem_rdata_valid_i,

  // tag store
  output icache_geom_pkg::tag_t    look_tag_o,
  output icache_geom_pkg::idx_t    look_idx_o,
  input  logic                     hit_i,
  output logic                     tag_we_o,
  output icache_geom_pkg::tag_t    wr_tag_o,
  output icache_geom_pkg::idx_t    wr_idx_o,

  // data store
  output logic                     data_we_o,
  output icache_geom_pkg::beat_t   wr_beat_o,
  output icache_bus_pkg::word_t    wr_word_o,
  output icache_geom_pkg::idx_t    rd_idx_o,
  output icache_geom_pkg::beat_t   rd_beat_o,
  input  icache_bus_pkg::word_t    rd_word_i
);

  localparam icache_geom_pkg::beat_t LAST_BEAT =
    icache_geom_pkg::beat_t'(icache_geom_pkg::WORDS_PER_LINE - 1);

  icache_bus_pkg::ctrl_state_t   state_q;

  // live fetch address and the one under lookup
  icache_geom_pkg::addr_fields_t fetch_f;
  icache_geom_pkg::addr_fields_t cap_q;

  // memory request
  icache_bus_pkg::mem_req_t      req_q;
  logic                          req_valid_q;
  icache_geom_pkg::beat_t        cnt_q;

  // tag write pulse, lands in the idle cycle after refill
  logic                          tag_we_q;

  // word from a single uncached read
  icache_bus_pkg::word_t         unc_word_q;
  logic                          unc_valid_q;

  logic                          is_uncached;
  logic                          beat_fire;

  always_comb begin
    fetch_f     = fetch_addr_i;
    is_uncached = (icache_bus_pkg::addr_t'(cap_q) & UNCACHED_MASK) == UNCACHED_BASE;
    // one beat per cycle with data strobe while request is up
    beat_fire   = req_valid_q && mem_rdata_valid_i;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= icache_bus_pkg::IDLE;
      req_valid_q <= 1'b0;
      cnt_q       <= '0;
      tag_we_q    <= 1'b0;
      unc_valid_q <= 1'b0;
    end else begin
      // pulses
      tag_we_q    <= 1'b0;
      unc_valid_q <= 1'b0;
      case (state_q)
        icache_bus_pkg::IDLE: begin
          cap_q <= fetch_f;
          if (fetch_valid_i) begin
            state_q <= icache_bus_pkg::LOOKUP;
          end
        end
        icache_bus_pkg::LOOKUP: begin
          if (is_uncached) begin
            // exact word, single beat
            state_q        <= icache_bus_pkg::UNCACHED;
            req_valid_q    <= 1'b1;
            req_q.addr     <= icache_bus_pkg::addr_t'(cap_q);
            req_q.len      <= 8'd0;
            req_q.size     <= 4'd4;
          end else if (!hit_i) begin
            // whole line, offset cleared
            state_q        <= icache_bus_pkg::REFILL;
            req_valid_q    <= 1'b1;
            req_q.addr     <= {cap_q.tag, cap_q.idx, {icache_geom_pkg::OFS_W{1'b0}}};
            req_q.len      <= 8'(icache_geom_pkg::WORDS_PER_LINE - 1);
            req_q.size     <= 4'd4;
            cnt_q          <= '0;
          end else begin
            // hit, take the next address right away
            cap_q <= fetch_f;
            if (!fetch_valid_i) begin
              state_q <= icache_bus_pkg::IDLE;
            end
          end
        end
        icache_bus_pkg::REFILL: begin
          if (beat_fire) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == LAST_BEAT) begin
              state_q     <= icache_bus_pkg::IDLE;
              req_valid_q <= 1'b0;
              tag_we_q    <= 1'b1;
            end
          end
        end
        icache_bus_pkg::UNCACHED: begin
          if (beat_fire) begin
            state_q     <= icache_bus_pkg::IDLE;
            req_valid_q <= 1'b0;
            unc_word_q  <= mem_rdata_i;
            unc_valid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= icache_bus_pkg::IDLE;
        end
      endcase
    end
  end

  // lookup and tag write both work on the captured address
  always_comb begin
    look_tag_o = cap_q.tag;
    look_idx_o = cap_q.idx;
    tag_we_o   = tag_we_q;
    wr_tag_o   = cap_q.tag;
    wr_idx_o   = cap_q.idx;
  end

  // refill beats go in at the counter position
  always_comb begin
    data_we_o = (state_q == icache_bus_pkg::REFILL) && beat_fire;
    wr_beat_o = cnt_q;
    wr_word_o = mem_rdata_i;
  end

  // read from the live address so the word is there in lookup
  always_comb begin
    rd_idx_o  = fetch_f.idx;
    rd_beat_o = fetch_f.beat;
  end

  // uncached word pulses in idle, cached word comes out in lookup
  always_comb begin
    fetch_rdata_valid_o = unc_valid_q ||
                          ((state_q == icache_bus_pkg::LOOKUP) && hit_i && !is_uncached);
    fetch_rdata_o       = unc_valid_q ? unc_word_q : rd_word_i;
    mem_req_o           = req_q;
    mem_req_valid_o     = req_valid_q;
  end

endmodule

// ==== hdl/icache_top.sv ====
module icache_top #(
  parameter icache_bus_pkg::addr_t UNCACHED_BASE = 32'h1000_0000,
  parameter icache_bus_pkg::addr_t UNCACHED_MASK = 32'hF000_0000
) (
  input  logic                     clk,
  input  logic                     rst,

  // fetch side
  input  icache_bus_pkg::addr_t    fetch_addr_i,
  input  logic                     fetch_valid_i,
  output icache_bus_pkg::word_t    fetch_rdata_o,
  output logic                     fetch_rdata_valid_o,

  // memory side
  output icache_bus_pkg::mem_req_t mem_req_o,
  output logic                     mem_req_valid_o,
  input  icache_bus_pkg::word_t    mem_rdata_i,
  input  logic                     mem_rdata_valid_i
);

  // tag store links
  icache_geom_pkg::tag_t  look_tag;
  icache_geom_pkg::idx_t  look_idx;
  logic                   hit;
  logic                   tag_we;
  icache_geom_pkg::tag_t  wr_tag;
  icache_geom_pkg::idx_t  wr_idx;

  // data store links, write index shared with the tag store
  logic                   data_we;
  icache_geom_pkg::beat_t wr_beat;
  icache_bus_pkg::word_t  wr_word;
  icache_geom_pkg::idx_t  rd_idx;
  icache_geom_pkg::beat_t rd_beat;
  icache_bus_pkg::word_t  rd_word;

  icache_ctrl #(
    .UNCACHED_BASE (UNCACHED_BASE),
    .UNCACHED_MASK (UNCACHED_MASK)
  ) u_ctrl (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rdata_o       (fetch_rdata_o),
    .fetch_rdata_valid_o (fetch_rdata_valid_o),
    .mem_req_o           (mem_req_o),
    .mem_req_valid_o     (mem_req_valid_o),
    .mem_rdata_i         (mem_rdata_i),
    .mem_rdata_valid_i   (mem_rdata_valid_i),
    .look_tag_o          (look_tag),
    .look_idx_o          (look_idx),
    .hit_i               (hit),
    .tag_we_o            (tag_we),
    .wr_tag_o            (wr_tag),
    .wr_idx_o            (wr_idx),
    .data_we_o           (data_we),
    .wr_beat_o           (wr_beat),
    .wr_word_o           (wr_word),
    .rd_idx_o            (rd_idx),
    .rd_beat_o           (rd_beat),
    .rd_word_i           (rd_word)
  );

  icache_tag_store u_tag_store (
    .clk        (clk),
    .rst        (rst),
    .look_tag_i (look_tag),
    .look_idx_i (look_idx),
    .hit_o      (hit),
    .we_i       (tag_we),
    .wr_tag_i   (wr_tag),
    .wr_idx_i   (wr_idx)
  );

  icache_data_store u_data_store (
    .clk       (clk),
    .we_i      (data_we),
    .wr_idx_i  (wr_idx),
    .wr_beat_i (wr_beat),
    .wr_word_i (wr_word),
    .rd_idx_i  (rd_idx),
    .rd_beat_i (rd_beat),
    .rd_word_o (rd_word)
  );

endmodule

// ==== sim/icache_mem_model.sv ====
module icache_mem_model (
  input  logic                     clk,
  input  logic                     rst,
  input  icache_bus_pkg::mem_req_t req_i,
  input  logic                     req_valid_i,
  output icache_bus_pkg::word_t    rdata_o,
  output logic                     rdata_valid_o
);

  // data for address a is a xor this key
  localparam icache_bus_pkg::word_t DATA_KEY = 32'h5A5A_0F0F;

  // beats already moved for the open request
  logic [8:0] beats_done;

  initial begin
    rdata_o       = '0;
    rdata_valid_o = 1'b0;
    beats_done    = '0;
    forever begin
      @(posedge clk);
      #2;
      // strobe still shows its pre-edge level here
      // so a beat moved if it was up and the request is still open
      if (req_valid_i && rdata_valid_o) begin
        beats_done = beats_done + 9'd1;
      end
      #3;
      if (rst || !req_valid_i) begin
        // request closed so the next one starts at beat 0
        beats_done    = '0;
        rdata_valid_o = 1'b0;
        rdata_o       = '0;
      end else if (beats_done > {1'b0, req_i.len}) begin
        // all beats given and waiting for the request to drop
        rdata_valid_o = 1'b0;
      end else if (($urandom & 32'd3) == 32'd0) begin
        // random gap between beats
        rdata_valid_o = 1'b0;
      end else begin
        rdata_valid_o = 1'b1;
        // each beat steps one word up from the request address
        rdata_o       = (req_i.addr + {21'd0, beats_done, 2'b00}) ^ DATA_KEY;
      end
    end
  end

endmodule

// ==== sim/icache_tb.sv ====
module icache_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_FETCHES = 200;
  // cold 2 and stream 16 and uncached 2 and conflict 5 plus the sweep
  localparam int NUM_FETCHES  = 25 + RAND_FETCHES;
  localparam int FETCH_LIMIT  = 200;
  localparam logic [31:0] SEED = 32'hdc6c990b;
  localparam icache_bus_pkg::addr_t UNC_BASE = 32'h1000_0000;
  localparam icache_bus_pkg::addr_t UNC_MASK = 32'hF000_0000;

  logic                     clk;
  logic                     rst;
  icache_bus_pkg::addr_t    fetch_addr;
  logic                     fetch_valid;
  icache_bus_pkg::word_t    fetch_rdata;
  logic                     fetch_rdata_valid;
  icache_bus_pkg::mem_req_t mem_req;
  logic                     mem_req_valid;
  icache_bus_pkg::word_t    mem_rdata;
  logic                     mem_rdata_valid;

  // expected line state for hit prediction
  logic                     model_valid [128];
  icache_geom_pkg::tag_t    model_tag [128];

  // request monitor state
  int                       req_count;
  logic                     req_valid_prev;
  icache_bus_pkg::mem_req_t held_req;

  icache_top #(
    .UNCACHED_BASE (UNC_BASE),
    .UNCACHED_MASK (UNC_MASK)
  ) DUT (
    .clk                 (clk),
    .rst                 (rst),
    .fetch_addr_i        (fetch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_o       (fetch_rdata),
    .fetch_rdata_valid_o (fetch_rdata_valid),
    .mem_req_o           (mem_req),
    .mem_req_valid_o     (mem_req_valid),
    .mem_rdata_i         (mem_rdata),
    .mem_rdata_valid_i   (mem_rdata_valid)
  );

  icache_mem_model u_mem (
    .clk           (clk),
    .rst           (rst),
    .req_i         (mem_req),
    .req_valid_i   (mem_req_valid),
    .rdata_o       (mem_rdata),
    .rdata_valid_o (mem_rdata_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory rule for a word address
  function automatic icache_bus_pkg::word_t expected_word(input icache_bus_pkg::addr_t addr);
    return addr ^ 32'h5A5A_0F0F;
  endfunction

  function automatic logic in_uncached_region(input icache_bus_pkg::addr_t addr);
    return (addr & UNC_MASK) == UNC_BASE;
  endfunction

  function automatic logic model_hit(input icache_bus_pkg::addr_t addr);
    icache_geom_pkg::addr_fields_t f;
    f = icache_geom_pkg::addr_fields_t'(addr);
    return model_valid[f.idx] && (model_tag[f.idx] == f.tag);
  endfunction

  task automatic abort_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input icache_bus_pkg::word_t got,
                            input icache_bus_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_req(input string name, input icache_bus_pkg::mem_req_t got,
                           input icache_bus_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // both outputs must rest while reset settles
  task automatic check_quiet();
    if (fetch_rdata_valid || mem_req_valid) begin
      $display("cache output active around reset at %0t", $time);
      abort_run();
    end
  endtask

  task automatic idle_cycles(input int n);
    fetch_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #5;
    end
  endtask

  // present one address and hold it until its strobe
  task automatic fetch_word(input icache_bus_pkg::addr_t addr);
    int   start_reqs;
    int   want_reqs;
    int   cycles;
    logic predicted_hit;
    predicted_hit = !in_uncached_region(addr) && model_hit(addr);
    want_reqs     = predicted_hit ? 0 : 1;
    start_reqs    = req_count;
    fetch_addr    = addr;
    fetch_valid   = 1'b1;
    @(posedge clk);
    #5;
    cycles = 1;
    while (!fetch_rdata_valid) begin
      if (cycles >= FETCH_LIMIT) begin
        $display("no fetch data for address %h after %0d cycles", addr, cycles);
        abort_run();
      end
      @(posedge clk);
      #5;
      cycles++;
    end
    if (req_count - start_reqs != want_reqs) begin
      $display("address %h caused %0d memory requests instead of %0d at %0t",
               addr, req_count - start_reqs, want_reqs, $time);
      abort_run();
    end
    // a hit answers in the cycle after capture
    if (predicted_hit && cycles != 1) begin
      $display("hit on address %h took %0d cycles at %0t", addr, cycles, $time);
      abort_run();
    end
  endtask

  // every strobe belongs to the address still held by the requester
  initial begin : compare_words
    forever begin
      @(posedge clk);
      #2;
      if (fetch_rdata_valid && !fetch_valid) begin
        $display("fetch data strobe at %0t with no fetch pending", $time);
        abort_run();
      end else if (fetch_rdata_valid) begin
        check_word("fetch_rdata_o", fetch_rdata, expected_word(fetch_addr));
      end
    end
  end

  initial begin : request_monitor
    icache_bus_pkg::mem_req_t      exp;
    icache_geom_pkg::addr_fields_t f;
    req_count      = 0;
    req_valid_prev = 1'b0;
    held_req       = '0;
    for (int i = 0; i < 128; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    forever begin
      @(posedge clk);
      #2;
      if (mem_req_valid && !req_valid_prev) begin
        req_count++;
        f        = icache_geom_pkg::addr_fields_t'(fetch_addr);
        exp.size = 4'd4;
        if (in_uncached_region(fetch_addr)) begin
          // single word at the exact address
          exp.addr = fetch_addr;
          exp.len  = 8'd0;
        end else begin
          if (model_hit(fetch_addr)) begin
            $display("memory request at %0t for held address %h", $time, fetch_addr);
            abort_run();
          end
          // line burst from the aligned base
          exp.addr = fetch_addr & ~32'h3F;
          exp.len  = 8'd15;
          model_valid[f.idx] = 1'b1;
          model_tag[f.idx]   = f.tag;
        end
        check_req("mem_req_o", mem_req, exp);
        held_req = mem_req;
      end else if (mem_req_valid) begin
        // request stays put while valid
        check_req("mem_req_o", mem_req, held_req);
      end
      req_valid_prev = mem_req_valid;
    end
  end

  initial begin : watchdog
    #(NUM_FETCHES * 40 * CLK_PERIOD);
    $display("run did not finish within %0d time units", NUM_FETCHES * 40 * CLK_PERIOD);
    abort_run();
  end

  initial begin : stimulus
    icache_bus_pkg::addr_t addr;
    void'($urandom(SEED));
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_addr  = '0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #5;
      check_quiet();
    end
    rst = 1'b0;
    repeat (2) begin
      @(posedge clk);
      #5;
      check_quiet();
    end
    // cold miss then the same word again
    fetch_word(32'h0000_1234);
    fetch_word(32'h0000_1234);
    idle_cycles(2);
    // whole filled line back to back
    addr = 32'h0000_1200;
    repeat (16) begin
      fetch_word(addr);
      addr = addr + 32'd4;
    end
    idle_cycles(2);
    // uncached word twice and never kept
    fetch_word(32'h1000_0040);
    fetch_word(32'h1000_0040);
    idle_cycles(1);
    // same index with two tags
    fetch_word(32'h0000_0100);
    fetch_word(32'h0000_2100);
    fetch_word(32'h0000_0100);
    fetch_word(32'h0000_2100);
    fetch_word(32'h0000_0100);
    idle_cycles(1);
    // 32 KB window gives four tags per index
    repeat (RAND_FETCHES) begin
      if (($urandom & 32'd7) == 32'd0) begin
        addr = UNC_BASE | ($urandom & 32'h0000_0FFC);
      end else begin
        addr = $urandom & 32'h0000_7FFC;
      end
      fetch_word(addr);
      if (($urandom & 32'd7) == 32'd0) begin
        idle_cycles(int'($urandom & 32'd3) + 1);
      end
    end
    idle_cycles(4);
    $display("test passed");
    $finish;
  end

endmodule

// ==== icache_top.f ====
hdl/icache_geom_pkg.sv
hdl/icache_bus_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := icache_tb
RTL_TOP    := icache_top
FILELIST   := icache_top.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(OBJ_DIR) --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --top-module $(RTL_TOP)
RTL_FILES  := hdl/icache_geom_pkg.sv hdl/icache_bus_pkg.sv hdl/icache_tag_store.sv \
              hdl/icache_data_store.sv hdl/icache_ctrl.sv hdl/icache_top.sv
PASS_MSG   := test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)
